// ==== verilog/axi_sram_pkg.sv ====
/*
  AXI4 SRAM bridge shared types
*/

package axi_sram_pkg;

  // ----------------------------------------------------------------------
  // Fixed AXI field widths
  // ----------------------------------------------------------------------
  localparam int AXI_LEN_W  = 8;   // Beats minus one
  localparam int AXI_RESP_W = 2;

  // Kind of granted request
  typedef enum logic
  {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  // Burst engine states
  typedef enum logic [1:0]
  {
    EX_IDLE  = 2'b00,
    EX_READ  = 2'b01,
    EX_WRITE = 2'b10,
    EX_WRESP = 2'b11
  } exec_state_e;

  // AXI response codes of which only OKAY is driven
  typedef enum logic [AXI_RESP_W-1:0]
  {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

endpackage

// ==== verilog/axi_req_decode.sv ====
/*
  AXI address channel arbiter
*/

module axi_req_decode
  import axi_sram_pkg::*;
#(
  parameter int ID_WIDTH       = 4,
  parameter int ADDR_WIDTH     = 32,
  parameter int DATA_WIDTH     = 64,
  parameter int MEM_ADDR_WIDTH = 10
)
(
  input  logic                      ACLK,
  input  logic                      ARESETn,

  // Write address channel
  input  logic [ID_WIDTH-1:0]       awid_i,
  input  logic [ADDR_WIDTH-1:0]     awaddr_i,
  input  logic [AXI_LEN_W-1:0]      awlen_i,
  input  logic                      awvalid_i,
  output logic                      awready_o,

  // Read address channel
  input  logic [ID_WIDTH-1:0]       arid_i,
  input  logic [ADDR_WIDTH-1:0]     araddr_i,
  input  logic [AXI_LEN_W-1:0]      arlen_i,
  input  logic                      arvalid_i,
  output logic                      arready_o,

  // Command to the burst engine
  output logic                      cmd_valid_o,
  output op_e                       cmd_op_o,
  output logic [ID_WIDTH-1:0]       cmd_id_o,
  output logic [MEM_ADDR_WIDTH-1:0] cmd_addr_o,
  output logic [AXI_LEN_W-1:0]      cmd_len_o,
  input  logic                      cmd_ready_i
);

  // Byte lane bits below the word address
  localparam int OFFSET_BITS = $clog2(DATA_WIDTH / 8);

  logic prio_wr_q;   // 1 favours AW, 0 favours AR
  logic can_grant;
  logic grant_aw;
  logic grant_ar;

  // ----------------------------------------------------------------------
  // Grant logic
  // ----------------------------------------------------------------------
  // Engine idle and no command waiting
  assign can_grant = cmd_ready_i & ~cmd_valid_o;

  assign grant_aw = can_grant & awvalid_i & (~arvalid_i | prio_wr_q);
  assign grant_ar = can_grant & arvalid_i & ~grant_aw;

  assign awready_o = grant_aw;
  assign arready_o = grant_ar;

  // Priority flips only when something was granted
  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
      prio_wr_q <= 1'b0;
    else if (grant_aw | grant_ar)
      prio_wr_q <= ~prio_wr_q;
  end

  // ----------------------------------------------------------------------
  // Command register
  // ----------------------------------------------------------------------
  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
      cmd_valid_o <= 1'b0;
    else if (grant_aw | grant_ar)
      cmd_valid_o <= 1'b1;
    else if (cmd_ready_i)
      cmd_valid_o <= 1'b0;   // Taken by the engine
  end

  always_ff @(posedge ACLK)
  begin
    if (grant_aw)
    begin
      cmd_op_o   <= OP_WRITE;
      cmd_id_o   <= awid_i;
      cmd_addr_o <= awaddr_i[OFFSET_BITS +: MEM_ADDR_WIDTH];
      cmd_len_o  <= awlen_i;
    end
    else if (grant_ar)
    begin
      cmd_op_o   <= OP_READ;
      cmd_id_o   <= arid_i;
      cmd_addr_o <= araddr_i[OFFSET_BITS +: MEM_ADDR_WIDTH];
      cmd_len_o  <= arlen_i;
    end
  end

endmodule

// ==== verilog/axi_burst_exec.sv ====
/*
  Burst engine for the SRAM port
*/

module axi_burst_exec
  import axi_sram_pkg::*;
#(
  parameter int ID_WIDTH       = 4,
  parameter int DATA_WIDTH     = 64,
  parameter int MEM_ADDR_WIDTH = 10
)
(
  input  logic                      ACLK,
  input  logic                      ARESETn,

  // Command from decode
  input  logic                      cmd_valid_i,
  input  op_e                       cmd_op_i,
  input  logic [ID_WIDTH-1:0]       cmd_id_i,
  input  logic [MEM_ADDR_WIDTH-1:0] cmd_addr_i,
  input  logic [AXI_LEN_W-1:0]      cmd_len_i,
  output logic                      cmd_ready_o,

  // Write data channel
  input  logic [DATA_WIDTH-1:0]     wdata_i,
  input  logic [DATA_WIDTH/8-1:0]   wstrb_i,
  input  logic                      wvalid_i,
  output logic                      wready_o,

  // SRAM port
  output logic                      cen_o,
  output logic                      wen_o,
  output logic [MEM_ADDR_WIDTH-1:0] a_o,
  output logic [DATA_WIDTH-1:0]     d_o,
  output logic [DATA_WIDTH/8-1:0]   be_o,

  // Read beat tags to result
  output logic                      rd_issue_o,
  output logic                      rd_last_o,
  output logic [ID_WIDTH-1:0]       rd_id_o,
  input  logic                      rd_credit_i,

  // Write completion to result
  output logic                      wr_done_o,
  output logic [ID_WIDTH-1:0]       wr_id_o,
  input  logic                      b_free_i
);

  exec_state_e               state_q;
  exec_state_e               state_d;
  logic [AXI_LEN_W-1:0]      beats_q;   // Beats left after the current one
  logic [MEM_ADDR_WIDTH-1:0] addr_q;
  logic [ID_WIDTH-1:0]       id_q;
  logic                      cmd_take;
  logic                      beat_step;
  logic                      last_beat;

  assign cmd_take  = cmd_ready_o & cmd_valid_i;
  assign last_beat = (beats_q == '0);

  // ----------------------------------------------------------------------
  // Next state and SRAM strobes
  // ----------------------------------------------------------------------
  always_comb
  begin
    state_d     = state_q;
    cmd_ready_o = 1'b0;
    wready_o    = 1'b0;
    cen_o       = 1'b1;
    wen_o       = 1'b1;
    rd_issue_o  = 1'b0;
    wr_done_o   = 1'b0;
    beat_step   = 1'b0;

    case (state_q)
      EX_IDLE:
      begin
        cmd_ready_o = 1'b1;
        if (cmd_valid_i)
          state_d = (cmd_op_i == OP_WRITE) ? EX_WRITE : EX_READ;
      end

      EX_READ:
      begin
        if (rd_credit_i)   // Room left in the R queue
        begin
          cen_o      = 1'b0;
          rd_issue_o = 1'b1;
          beat_step  = 1'b1;
          if (last_beat)
            state_d = EX_IDLE;
        end
      end

      EX_WRITE:
      begin
        wready_o = 1'b1;
        if (wvalid_i)
        begin
          cen_o     = 1'b0;
          wen_o     = 1'b0;
          beat_step = 1'b1;
          if (last_beat)
          begin
            wr_done_o = 1'b1;   // B register loads next edge
            state_d   = EX_WRESP;
          end
        end
      end

      EX_WRESP:
      begin
        if (b_free_i)
          state_d = EX_IDLE;
      end

      default: state_d = EX_IDLE;
    endcase
  end

  assign a_o       = addr_q;
  assign d_o       = wdata_i;
  assign be_o      = wstrb_i;
  assign rd_last_o = last_beat;
  assign rd_id_o   = id_q;
  assign wr_id_o   = id_q;

  // ----------------------------------------------------------------------
  // State and beat counter
  // ----------------------------------------------------------------------
  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      state_q <= EX_IDLE;
      beats_q <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (cmd_take)
        beats_q <= cmd_len_i;
      else if (beat_step)
        beats_q <= beats_q - 1'b1;
    end
  end

  // Word address wraps at the top of the memory
  always_ff @(posedge ACLK)
  begin
    if (cmd_take)
    begin
      addr_q <= cmd_addr_i;
      id_q   <= cmd_id_i;
    end
    else if (beat_step)
      addr_q <= addr_q + 1'b1;
  end

endmodule

// ==== verilog/axi_resp_gen.sv ====
/*
  R and B channel responder
*/

module axi_resp_gen
  import axi_sram_pkg::*;
#(
  parameter int ID_WIDTH   = 4,
  parameter int DATA_WIDTH = 64
)
(
  input  logic                  ACLK,
  input  logic                  ARESETn,

  // Read beat tags from execute
  input  logic                  rd_issue_i,
  input  logic                  rd_last_i,
  input  logic [ID_WIDTH-1:0]   rd_id_i,
  output logic                  rd_credit_o,

  // SRAM read data
  input  logic [DATA_WIDTH-1:0] q_i,

  // Read data channel
  output logic [ID_WIDTH-1:0]   rid_o,
  output logic [DATA_WIDTH-1:0] rdata_o,
  output logic [AXI_RESP_W-1:0] rresp_o,
  output logic                  rlast_o,
  output logic                  rvalid_o,
  input  logic                  rready_i,

  // Write completion
  input  logic                  wr_done_i,
  input  logic [ID_WIDTH-1:0]   wr_id_i,
  output logic                  b_free_o,

  // Write response channel
  output logic [ID_WIDTH-1:0]   bid_o,
  output logic [AXI_RESP_W-1:0] bresp_o,
  output logic                  bvalid_o,
  input  logic                  bready_i
);

  // Tag of the read in flight in the SRAM
  logic                  tag_v_q;
  logic                  tag_last_q;
  logic [ID_WIDTH-1:0]   tag_id_q;

  // Two-entry R queue
  logic [ID_WIDTH-1:0]   fifo_id   [2];
  logic [DATA_WIDTH-1:0] fifo_data [2];
  logic                  fifo_last [2];
  logic                  wr_ptr_q;
  logic                  rd_ptr_q;
  logic [1:0]            count_q;
  logic [1:0]            in_use;
  logic                  push;
  logic                  pop;

  assign push = tag_v_q;   // q_i lines up with the tag
  assign pop  = rvalid_o & rready_i;

  // Queued beats plus the one still in the SRAM
  assign in_use      = count_q + {1'b0, tag_v_q};
  assign rd_credit_o = (in_use < 2'd2);

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
      tag_v_q <= 1'b0;
    else
      tag_v_q <= rd_issue_i;
  end

  always_ff @(posedge ACLK)
  begin
    tag_last_q <= rd_last_i;
    tag_id_q   <= rd_id_i;
    if (push)
    begin
      fifo_id[wr_ptr_q]   <= tag_id_q;
      fifo_data[wr_ptr_q] <= q_i;
      fifo_last[wr_ptr_q] <= tag_last_q;
    end
  end

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= ~wr_ptr_q;
      if (pop)
        rd_ptr_q <= ~rd_ptr_q;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign rvalid_o = (count_q != '0);
  assign rid_o    = fifo_id[rd_ptr_q];
  assign rdata_o  = fifo_data[rd_ptr_q];
  assign rlast_o  = fifo_last[rd_ptr_q];
  assign rresp_o  = RESP_OKAY;

  // ----------------------------------------------------------------------
  // Write response register
  // ----------------------------------------------------------------------
  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
      bvalid_o <= 1'b0;
    else if (wr_done_i)
      bvalid_o <= 1'b1;
    else if (bready_i)
      bvalid_o <= 1'b0;   // Accepted
  end

  always_ff @(posedge ACLK)
  begin
    if (wr_done_i)
      bid_o <= wr_id_i;
  end

  assign bresp_o  = RESP_OKAY;
  assign b_free_o = ~bvalid_o;

endmodule

// ==== verilog/axi_sram_bridge.sv ====
/*
  AXI4 slave to SRAM bridge
*/

module axi_sram_bridge
  import axi_sram_pkg::*;
#(
  parameter int ID_WIDTH       = 4,
  parameter int ADDR_WIDTH     = 32,
  parameter int DATA_WIDTH     = 64,
  parameter int MEM_ADDR_WIDTH = 10
)
(
  input  logic                      ACLK,
  input  logic                      ARESETn,

  // Write address channel
  input  logic [ID_WIDTH-1:0]       awid_i,
  input  logic [ADDR_WIDTH-1:0]     awaddr_i,
  input  logic [AXI_LEN_W-1:0]      awlen_i,
  input  logic                      awvalid_i,
  output logic                      awready_o,

  // Write data channel
  input  logic [DATA_WIDTH-1:0]     wdata_i,
  input  logic [DATA_WIDTH/8-1:0]   wstrb_i,
  input  logic                      wvalid_i,
  output logic                      wready_o,

  // Write response channel
  output logic [ID_WIDTH-1:0]       bid_o,
  output logic [AXI_RESP_W-1:0]     bresp_o,
  output logic                      bvalid_o,
  input  logic                      bready_i,

  // Read address channel
  input  logic [ID_WIDTH-1:0]       arid_i,
  input  logic [ADDR_WIDTH-1:0]     araddr_i,
  input  logic [AXI_LEN_W-1:0]      arlen_i,
  input  logic                      arvalid_i,
  output logic                      arready_o,

  // Read data channel
  output logic [ID_WIDTH-1:0]       rid_o,
  output logic [DATA_WIDTH-1:0]     rdata_o,
  output logic [AXI_RESP_W-1:0]     rresp_o,
  output logic                      rlast_o,
  output logic                      rvalid_o,
  input  logic                      rready_i,

  // Single-port SRAM
  output logic                      cen_o,
  output logic                      wen_o,
  output logic [MEM_ADDR_WIDTH-1:0] a_o,
  output logic [DATA_WIDTH-1:0]     d_o,
  output logic [DATA_WIDTH/8-1:0]   be_o,
  input  logic [DATA_WIDTH-1:0]     q_i
);

  // ----------------------------------------------------------------------
  // Internal links
  // ----------------------------------------------------------------------
  logic                      cmd_valid;
  op_e                       cmd_op;
  logic [ID_WIDTH-1:0]       cmd_id;
  logic [MEM_ADDR_WIDTH-1:0] cmd_addr;
  logic [AXI_LEN_W-1:0]      cmd_len;
  logic                      cmd_ready;

  logic                      rd_issue;
  logic                      rd_last;
  logic [ID_WIDTH-1:0]       rd_id;
  logic                      rd_credit;
  logic                      wr_done;
  logic [ID_WIDTH-1:0]       wr_id;
  logic                      b_free;

  axi_req_decode #(
    .ID_WIDTH       (ID_WIDTH),
    .ADDR_WIDTH     (ADDR_WIDTH),
    .DATA_WIDTH     (DATA_WIDTH),
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) u_decode (
    .ACLK        (ACLK),
    .ARESETn     (ARESETn),
    .awid_i      (awid_i),
    .awaddr_i    (awaddr_i),
    .awlen_i     (awlen_i),
    .awvalid_i   (awvalid_i),
    .awready_o   (awready_o),
    .arid_i      (arid_i),
    .araddr_i    (araddr_i),
    .arlen_i     (arlen_i),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .cmd_valid_o (cmd_valid),
    .cmd_op_o    (cmd_op),
    .cmd_id_o    (cmd_id),
    .cmd_addr_o  (cmd_addr),
    .cmd_len_o   (cmd_len),
    .cmd_ready_i (cmd_ready)
  );

  axi_burst_exec #(
    .ID_WIDTH       (ID_WIDTH),
    .DATA_WIDTH     (DATA_WIDTH),
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) u_exec (
    .ACLK        (ACLK),
    .ARESETn     (ARESETn),
    .cmd_valid_i (cmd_valid),
    .cmd_op_i    (cmd_op),
    .cmd_id_i    (cmd_id),
    .cmd_addr_i  (cmd_addr),
    .cmd_len_i   (cmd_len),
    .cmd_ready_o (cmd_ready),
    .wdata_i     (wdata_i),
    .wstrb_i     (wstrb_i),
    .wvalid_i    (wvalid_i),
    .wready_o    (wready_o),
    .cen_o       (cen_o),
    .wen_o       (wen_o),
    .a_o         (a_o),
    .d_o         (d_o),
    .be_o        (be_o),
    .rd_issue_o  (rd_issue),
    .rd_last_o   (rd_last),
    .rd_id_o     (rd_id),
    .rd_credit_i (rd_credit),
    .wr_done_o   (wr_done),
    .wr_id_o     (wr_id),
    .b_free_i    (b_free)
  );

  axi_resp_gen #(
    .ID_WIDTH   (ID_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_resp (
    .ACLK        (ACLK),
    .ARESETn     (ARESETn),
    .rd_issue_i  (rd_issue),
    .rd_last_i   (rd_last),
    .rd_id_i     (rd_id),
    .rd_credit_o (rd_credit),
    .q_i         (q_i),
    .rid_o       (rid_o),
    .rdata_o     (rdata_o),
    .rresp_o     (rresp_o),
    .rlast_o     (rlast_o),
    .rvalid_o    (rvalid_o),
    .rready_i    (rready_i),
    .wr_done_i   (wr_done),
    .wr_id_i     (wr_id),
    .b_free_o    (b_free),
    .bid_o       (bid_o),
    .bresp_o     (bresp_o),
    .bvalid_o    (bvalid_o),
    .bready_i    (bready_i)
  );

endmodule

// ==== sim/tb_clock_gen.sv ====
/*
  Testbench clock and reset
*/

module tb_clock_gen
#(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 8
)
(
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;   // Release just after an edge
  end

  always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

// ==== sim/axi_sram_bridge_checker.sv ====
/*
  Bound AXI and SRAM protocol checks
*/

module axi_sram_bridge_checker
  import axi_sram_pkg::*;
#(
  parameter int ID_WIDTH   = 4,
  parameter int DATA_WIDTH = 64
)
(
  input logic                  ACLK,
  input logic                  ARESETn,
  input logic                  rvalid_i,
  input logic                  rready_i,
  input logic [ID_WIDTH-1:0]   rid_i,
  input logic [DATA_WIDTH-1:0] rdata_i,
  input logic                  rlast_i,
  input logic [AXI_RESP_W-1:0] rresp_i,
  input logic                  bvalid_i,
  input logic                  bready_i,
  input logic [ID_WIDTH-1:0]   bid_i,
  input logic [AXI_RESP_W-1:0] bresp_i,
  input logic                  wen_i,
  input logic                  wvalid_i,
  input logic                  wready_i
);

  int unsigned assert_failures = 0;

  // R beat held while the master stalls
  property r_hold;
    @(posedge ACLK) disable iff (!ARESETn)
      (rvalid_i && !rready_i) |=>
        (rvalid_i && $stable(rid_i) && $stable(rdata_i) && $stable(rlast_i)
         && $stable(rresp_i));
  endproperty

  property b_hold;
    @(posedge ACLK) disable iff (!ARESETn)
      (bvalid_i && !bready_i) |=> (bvalid_i && $stable(bid_i) && $stable(bresp_i));
  endproperty

  // SRAM write strobe only on a W handshake
  property wen_on_w_transfer;
    @(posedge ACLK) disable iff (!ARESETn)
      !wen_i |-> (wvalid_i && wready_i);
  endproperty

  r_hold_a: assert property (r_hold)
    else
    begin
      $error("RVALID or R payload changed before RREADY");
      assert_failures++;
    end

  b_hold_a: assert property (b_hold)
    else
    begin
      $error("BVALID or B payload changed before BREADY");
      assert_failures++;
    end

  wen_a: assert property (wen_on_w_transfer)
    else
    begin
      $error("SRAM write outside a W transfer");
      assert_failures++;
    end

endmodule

bind axi_sram_bridge axi_sram_bridge_checker #(
  .ID_WIDTH   (ID_WIDTH),
  .DATA_WIDTH (DATA_WIDTH)
) u_checker (
  .ACLK     (ACLK),
  .ARESETn  (ARESETn),
  .rvalid_i (rvalid_o),
  .rready_i (rready_i),
  .rid_i    (rid_o),
  .rdata_i  (rdata_o),
  .rlast_i  (rlast_o),
  .rresp_i  (rresp_o),
  .bvalid_i (bvalid_o),
  .bready_i (bready_i),
  .bid_i    (bid_o),
  .bresp_i  (bresp_o),
  .wen_i    (wen_o),
  .wvalid_i (wvalid_i),
  .wready_i (wready_o)
);

// ==== sim/tb_axi_sram_bridge.sv ====
/*
  AXI SRAM bridge testbench
*/

module tb_axi_sram_bridge
  import axi_sram_pkg::*;
();

  localparam int ID_WIDTH       = 4;
  localparam int ADDR_WIDTH     = 32;
  localparam int DATA_WIDTH     = 64;
  localparam int MEM_ADDR_WIDTH = 8;
  localparam int STRB_WIDTH     = DATA_WIDTH / 8;
  localparam int MEM_DEPTH      = 1 << MEM_ADDR_WIDTH;
  localparam int OFFSET_BITS    = $clog2(STRB_WIDTH);
  localparam int TIMEOUT        = 2000;   // Cycles per wait loop
  localparam int DRIVE_DELAY    = 2;

  logic                      ACLK;
  logic                      ARESETn;
  logic [ID_WIDTH-1:0]       awid;
  logic [ADDR_WIDTH-1:0]     awaddr;
  logic [AXI_LEN_W-1:0]      awlen;
  logic                      awvalid;
  logic                      awready;
  logic [DATA_WIDTH-1:0]     wdata;
  logic [STRB_WIDTH-1:0]     wstrb;
  logic                      wvalid;
  logic                      wready;
  logic [ID_WIDTH-1:0]       bid;
  logic [AXI_RESP_W-1:0]     bresp;
  logic                      bvalid;
  logic                      bready;
  logic [ID_WIDTH-1:0]       arid;
  logic [ADDR_WIDTH-1:0]     araddr;
  logic [AXI_LEN_W-1:0]      arlen;
  logic                      arvalid;
  logic                      arready;
  logic [ID_WIDTH-1:0]       rid;
  logic [DATA_WIDTH-1:0]     rdata;
  logic [AXI_RESP_W-1:0]     rresp;
  logic                      rlast;
  logic                      rvalid;
  logic                      rready;
  logic                      cen;
  logic                      wen;
  logic [MEM_ADDR_WIDTH-1:0] a;
  logic [DATA_WIDTH-1:0]     d;
  logic [STRB_WIDTH-1:0]     be;
  logic [DATA_WIDTH-1:0]     q;

  logic [31:0]               lfsr_q = 32'hf401_635a;
  logic                      stall_mode;             // Random RREADY and BREADY
  logic [DATA_WIDTH-1:0]     sram [MEM_DEPTH];
  logic [7:0]                ref_mem [MEM_DEPTH][STRB_WIDTH];

  tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(8)) u_clk (.clk_o(ACLK), .rst_n_o(ARESETn));

  axi_sram_bridge #(
    .ID_WIDTH       (ID_WIDTH),
    .ADDR_WIDTH     (ADDR_WIDTH),
    .DATA_WIDTH     (DATA_WIDTH),
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) dut_i (
    .ACLK (ACLK), .ARESETn (ARESETn),
    .awid_i (awid), .awaddr_i (awaddr), .awlen_i (awlen),
    .awvalid_i (awvalid), .awready_o (awready),
    .wdata_i (wdata), .wstrb_i (wstrb), .wvalid_i (wvalid), .wready_o (wready),
    .bid_o (bid), .bresp_o (bresp), .bvalid_o (bvalid), .bready_i (bready),
    .arid_i (arid), .araddr_i (araddr), .arlen_i (arlen),
    .arvalid_i (arvalid), .arready_o (arready),
    .rid_o (rid), .rdata_o (rdata), .rresp_o (rresp), .rlast_o (rlast),
    .rvalid_o (rvalid), .rready_i (rready),
    .cen_o (cen), .wen_o (wen), .a_o (a), .d_o (d), .be_o (be), .q_i (q)
  );

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  // Galois LFSR stepped once per bit
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] val;
    logic        bit_out;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      bit_out = lfsr_q[0];
      lfsr_q  = lfsr_q >> 1;
      if (bit_out)
        lfsr_q = lfsr_q ^ 32'h8020_0003;
      val = {val[62:0], bit_out};
    end
    return val;
  endfunction

  function automatic logic pick_ready();
    if (stall_mode)
      return (take_bits(2) != 0);   // Ready three times in four
    return 1'b1;
  endfunction

  // Every byte depends on the whole word address
  function automatic logic [DATA_WIDTH-1:0] fill_word(input int addr);
    logic [7:0] w;
    w = addr[7:0];
    return {4{w, ~w}} ^ 64'h0123_4567_89ab_cdef;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] expected_word(
    input logic [MEM_ADDR_WIDTH-1:0] word);
    logic [DATA_WIDTH-1:0] val;
    for (int b = 0; b < STRB_WIDTH; b++)
      val[b*8 +: 8] = ref_mem[word][b];
    return val;
  endfunction

  function automatic void update_ref(input logic [MEM_ADDR_WIDTH-1:0] word,
                                     input logic [DATA_WIDTH-1:0] data,
                                     input logic [STRB_WIDTH-1:0] strb);
    for (int b = 0; b < STRB_WIDTH; b++)
      if (strb[b])
        ref_mem[word][b] = data[b*8 +: 8];
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected)
    begin
      $display("ERROR: %s is 0x%0h, expected 0x%0h", name, actual, expected);
      $display("TEST FAIL");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timed out waiting for %s", what);
    $display("TEST FAIL");
    $fatal(1, "Stopped on a timeout");
  endtask

  task automatic step_to_drive();
    @(posedge ACLK);
    #DRIVE_DELAY;
  endtask

  // Protocol assertions stop the run at once
  always @(negedge ACLK)
  begin
    if (dut_i.u_checker.assert_failures != 0)
    begin
      $display("A protocol assertion failed");
      $display("TEST FAIL");
      $fatal(1, "Stopped on an assertion failure");
    end
  end

  // SRAM model with read data one cycle after the read
  initial
  begin
    for (int i = 0; i < MEM_DEPTH; i++)
      sram[i] = fill_word(i);
  end

  always @(posedge ACLK)
  begin
    if (!cen && !wen)
    begin
      for (int b = 0; b < STRB_WIDTH; b++)
        if (be[b])
          sram[a][b*8 +: 8] = d[b*8 +: 8];
    end
    else if (!cen)
      q <= #DRIVE_DELAY sram[a];
  end

  // ----------------------------------------------------------------------
  // Transactions
  // ----------------------------------------------------------------------
  task automatic run_write(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr,
                           input logic [AXI_LEN_W-1:0] len);
    int                        waited;
    logic [MEM_ADDR_WIDTH-1:0] cur;
    logic [DATA_WIDTH-1:0]     data;
    logic [STRB_WIDTH-1:0]     strb;
    cur = addr[OFFSET_BITS +: MEM_ADDR_WIDTH];
    step_to_drive();
    awid    = id;
    awaddr  = addr;
    awlen   = len;
    awvalid = 1'b1;
    waited  = 0;
    @(negedge ACLK);
    while (!awready)
    begin
      waited++;
      if (waited > TIMEOUT)
        timeout_fail("the AW grant");
      @(negedge ACLK);
    end
    step_to_drive();
    awvalid = 1'b0;

    for (int beat = 0; beat <= len; beat++)
    begin
      if (stall_mode && take_bits(1))
        step_to_drive();   // Gap in W
      data   = take_bits(DATA_WIDTH);
      strb   = take_bits(STRB_WIDTH);
      wdata  = data;
      wstrb  = strb;
      wvalid = 1'b1;
      waited = 0;
      @(negedge ACLK);
      while (!wready)
      begin
        waited++;
        if (waited > TIMEOUT)
          timeout_fail("WREADY");
        @(negedge ACLK);
      end
      update_ref(cur, data, strb);
      cur++;
      step_to_drive();
      wvalid = 1'b0;
    end

    bready = pick_ready();
    @(negedge ACLK);
    check_value("bvalid", bvalid, 1'b1);   // One cycle after the last beat
    waited = 0;
    while (!(bvalid && bready))
    begin
      waited++;
      if (waited > TIMEOUT)
        timeout_fail("the B handshake");
      step_to_drive();
      bready = pick_ready();
      @(negedge ACLK);
    end
    check_value("bid", bid, id);
    check_value("bresp", bresp, RESP_OKAY);
    step_to_drive();
    bready = 1'b0;
  endtask

  task automatic run_read(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr,
                          input logic [AXI_LEN_W-1:0] len);
    int                        waited;
    int                        beat;
    logic [MEM_ADDR_WIDTH-1:0] cur;
    cur = addr[OFFSET_BITS +: MEM_ADDR_WIDTH];
    step_to_drive();
    arid    = id;
    araddr  = addr;
    arlen   = len;
    arvalid = 1'b1;
    waited  = 0;
    @(negedge ACLK);
    while (!arready)
    begin
      waited++;
      if (waited > TIMEOUT)
        timeout_fail("the AR grant");
      @(negedge ACLK);
    end
    step_to_drive();
    arvalid = 1'b0;

    beat = 0;
    while (beat <= len)
    begin
      rready = pick_ready();
      waited = 0;
      @(negedge ACLK);
      while (!(rvalid && rready))
      begin
        waited++;
        if (waited > TIMEOUT)
          timeout_fail("an R beat");
        step_to_drive();
        rready = pick_ready();
        @(negedge ACLK);
      end
      check_value("rid", rid, id);
      check_value("rdata", rdata, expected_word(cur));
      check_value("rresp", rresp, RESP_OKAY);
      check_value("rlast", rlast, (beat == len));
      cur++;
      beat++;
      step_to_drive();
    end
    rready = 1'b0;
    @(negedge ACLK);
    check_value("rvalid", rvalid, 1'b0);   // No beat past RLAST
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial
  begin
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [ADDR_WIDTH-1:0] raddr;
    logic [AXI_LEN_W-1:0]  len;
    logic [AXI_LEN_W-1:0]  rlen;
    int                    waited;

    awid    = '0;
    awaddr  = '0;
    awlen   = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    arid    = '0;
    araddr  = '0;
    arlen   = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    q       = '0;
    stall_mode = 1'b0;
    for (int i = 0; i < MEM_DEPTH; i++)
      for (int b = 0; b < STRB_WIDTH; b++)
        ref_mem[i][b] = fill_word(i) >> (b * 8);

    waited = 0;
    @(negedge ACLK);
    while (!ARESETn)
    begin
      waited++;
      if (waited > TIMEOUT)
        timeout_fail("reset release");
      @(negedge ACLK);
    end

    // Idle outputs after reset
    check_value("awready", awready, 1'b0);
    check_value("arready", arready, 1'b0);
    check_value("wready", wready, 1'b0);
    check_value("rvalid", rvalid, 1'b0);
    check_value("bvalid", bvalid, 1'b0);
    check_value("cen", cen, 1'b1);
    check_value("wen", wen, 1'b1);

    // Single beats
    repeat (8)
    begin
      id   = take_bits(ID_WIDTH);
      addr = take_bits(ADDR_WIDTH);
      run_write(id, addr, 8'd0);
      run_read(~id, addr, 8'd0);
    end

    // Full memory burst then random bursts with and without stalls
    run_write(4'h3, take_bits(ADDR_WIDTH), 8'd255);
    run_read(4'hc, take_bits(ADDR_WIDTH), 8'd255);
    for (int pass = 0; pass < 2; pass++)
    begin
      stall_mode = (pass == 1);
      repeat (10)
      begin
        id   = take_bits(ID_WIDTH);
        addr = take_bits(ADDR_WIDTH);
        len  = take_bits(AXI_LEN_W);
        run_write(id, addr, len);
        run_read(id + 1'b1, addr, take_bits(AXI_LEN_W));
      end
    end

    // AW and AR together on disjoint word ranges
    repeat (6)
    begin
      // Odd grant count so the winner alternates
      run_read(take_bits(ID_WIDTH), take_bits(ADDR_WIDTH), 8'd0);
      id    = take_bits(ID_WIDTH);
      addr  = take_bits(ADDR_WIDTH);
      raddr = take_bits(ADDR_WIDTH);
      addr[OFFSET_BITS + MEM_ADDR_WIDTH - 2 +: 2]  = 2'b00;
      raddr[OFFSET_BITS + MEM_ADDR_WIDTH - 2 +: 2] = 2'b10;
      len   = take_bits(4);
      rlen  = take_bits(4);
      fork
        run_write(id, addr, len);
        run_read(~id, raddr, rlen);
      join
    end

    step_to_drive();
    if (dut_i.u_checker.assert_failures == 0)
    begin
      $display("TEST PASS");
      $finish;
    end
    else
    begin
      $display("Protocol assertions failed during the run");
      $display("TEST FAIL");
      $fatal(1, "Stopped after assertion failures");
    end
  end

endmodule

// ==== axi_sram_bridge.f ====
verilog/axi_sram_pkg.sv
verilog/axi_req_decode.sv
verilog/axi_burst_exec.sv
verilog/axi_resp_gen.sv
verilog/axi_sram_bridge.sv
sim/tb_clock_gen.sv
sim/axi_sram_bridge_checker.sv
sim/tb_axi_sram_bridge.sv
